// ==== icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  // fetch address, also the width of one instruction word
  localparam int addr_w = 64;

  // address fields: tag 63:11, index 10:5, word 4:3
  localparam int tag_w = 53;
  localparam int index_w = 6;
  localparam int word_sel_w = 2;

  // line geometry, one refill beat per word
  localparam int line_words = 4;
  localparam int line_w = line_words * addr_w;
  localparam int num_sets = 1 << index_w;

  // recency age, saturates at all ones
  localparam int age_w = 4;
  localparam logic [age_w-1:0] age_max = '1;

  // field positions inside a fetch address
  localparam int word_lsb = 3;
  localparam int index_lsb = word_lsb + word_sel_w;
  localparam int tag_lsb = index_lsb + index_w;

endpackage

`default_nettype wire

// ==== icache_ways.sv ====
`default_nettype none

module icache_ways
  import icache_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               rd_en,
  input  logic [index_w-1:0] rd_index,
  input  logic               wr_en,
  input  logic [index_w-1:0] wr_index,
  input  logic               wr_way,
  input  logic [tag_w-1:0]   wr_tag,
  input  logic [line_w-1:0]  wr_line,
  output logic               valid0,
  output logic               valid1,
  output logic [tag_w-1:0]   tag0,
  output logic [tag_w-1:0]   tag1,
  output logic [line_w-1:0]  line0,
  output logic [line_w-1:0]  line1
);

  // storage, first index is the way
  logic [num_sets-1:0] vld_bits [2];
  logic [tag_w-1:0]    tag_mem  [2][num_sets];
  logic [line_w-1:0]   data_mem [2][num_sets];

  // registered set read
  logic [1:0]          rd_valid;
  logic [tag_w-1:0]    rd_tag   [2];
  logic [line_w-1:0]   rd_line  [2];

  // valid bits, only ever set by a refill
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_bits[0] <= '0;
      vld_bits[1] <= '0;
    end else if (wr_en) begin
      vld_bits[wr_way][wr_index] <= 1'b1;
    end
  end

  // tag and line data of the victim way
  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[wr_way][wr_index]  <= wr_tag;
      data_mem[wr_way][wr_index] <= wr_line;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid <= '0;
    end else if (rd_en) begin
      rd_valid <= {vld_bits[1][rd_index], vld_bits[0][rd_index]};
    end
  end

  // both ways of the set, held until the next read
  always_ff @(posedge clk) begin
    if (rd_en) begin
      for (int w = 0; w < 2; w++) begin
        rd_tag[w]  <= tag_mem[w][rd_index];
        rd_line[w] <= data_mem[w][rd_index];
      end
    end
  end

  assign valid0 = rd_valid[0];
  assign valid1 = rd_valid[1];
  assign tag0   = rd_tag[0];
  assign tag1   = rd_tag[1];
  assign line0  = rd_line[0];
  assign line1  = rd_line[1];

endmodule

`default_nettype wire

// ==== icache_lru.sv ====
`default_nettype none

module icache_lru
  import icache_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               hit_valid,
  input  logic               hit_way,
  input  logic [index_w-1:0] hit_index,
  input  logic [index_w-1:0] fill_index,
  input  logic               valid0,
  input  logic               valid1,
  output logic               victim_way
);

  // age per way per set, larger means older
  logic [age_w-1:0] age [2][num_sets];
  logic             other_way;
  logic [age_w-1:0] other_age;

  assign other_way = ~hit_way;
  assign other_age = age[other_way][hit_index];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int w = 0; w < 2; w++) begin
        for (int s = 0; s < num_sets; s++) begin
          age[w][s] <= '0;
        end
      end
    end else if (hit_valid) begin
      age[hit_way][hit_index] <= '0;
      // saturating increment of the way not used
      if (other_age != age_max) begin
        age[other_way][hit_index] <= other_age + 1'b1;
      end
    end
  end

  // invalid way first, way 0 before way 1, then the older way
  always_comb begin
    if (!valid0) begin
      victim_way = 1'b0;
    end else if (!valid1) begin
      victim_way = 1'b1;
    end else if (age[0][fill_index] > age[1][fill_index]) begin
      victim_way = 1'b0;
    end else begin
      victim_way = 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== icache_refill.sv ====
`default_nettype none

module icache_refill
  import icache_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               miss,
  input  logic [addr_w-1:0]  miss_addr,
  input  logic [addr_w-1:0]  dram_data,
  input  logic               dram_val,
  output logic               dram_req,
  output logic [addr_w-1:0]  dram_req_addr,
  output logic               fill_done,
  output logic [index_w-1:0] fill_index,
  output logic [tag_w-1:0]   fill_tag,
  output logic [line_w-1:0]  fill_line
);

  localparam logic [word_sel_w-1:0] last_beat = word_sel_w'(line_words - 1);

  logic [addr_w-1:0]     line_addr;
  logic [word_sel_w-1:0] beat_cnt;
  logic [line_w-1:0]     line_buf;

  // line aligned miss address
  always_ff @(posedge clk) begin
    if (miss) begin
      line_addr <= {miss_addr[addr_w-1:index_lsb], {index_lsb{1'b0}}};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dram_req  <= 1'b0;
      beat_cnt  <= '0;
      fill_done <= 1'b0;
    end else begin
      fill_done <= 1'b0;
      if (miss) begin
        dram_req <= 1'b1;
        beat_cnt <= '0;
      end else if (dram_req && dram_val) begin
        beat_cnt <= beat_cnt + 1'b1;
        // last beat closes the request
        if (beat_cnt == last_beat) begin
          dram_req  <= 1'b0;
          fill_done <= 1'b1;
        end
      end
    end
  end

  // beats enter at the top, first beat ends up as word 0
  always_ff @(posedge clk) begin
    if (dram_req && dram_val) begin
      line_buf <= {dram_data, line_buf[line_w-1:addr_w]};
    end
  end

  assign dram_req_addr = line_addr;
  assign fill_index    = line_addr[index_lsb +: index_w];
  assign fill_tag      = line_addr[tag_lsb +: tag_w];
  assign fill_line     = line_buf;

endmodule

`default_nettype wire

// ==== icache_ctrl.sv ====
`default_nettype none

module icache_ctrl
  import icache_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               ins_req,
  input  logic [addr_w-1:0]  cpu_addr,
  input  logic               valid0,
  input  logic               valid1,
  input  logic [tag_w-1:0]   tag0,
  input  logic [tag_w-1:0]   tag1,
  input  logic [line_w-1:0]  line0,
  input  logic [line_w-1:0]  line1,
  input  logic               fill_done,
  input  logic               dram_req,
  output logic               rd_en,
  output logic [index_w-1:0] rd_index,
  output logic               hit_valid,
  output logic               hit_way,
  output logic [index_w-1:0] hit_index,
  output logic               miss,
  output logic [addr_w-1:0]  miss_addr,
  output logic [addr_w-1:0]  instruction,
  output logic               stall
);

  logic [addr_w-1:0]     addr_q;
  logic                  lookup_q;
  logic                  reread_q;
  logic                  hit0;
  logic                  hit1;
  logic                  hit;
  logic [line_w-1:0]     hit_line;
  logic [word_sel_w-1:0] word_sel;

  // request address, held for the whole miss
  always_ff @(posedge clk) begin
    if (ins_req) begin
      addr_q <= cpu_addr;
    end
  end

  // lookup_q marks the compare cycle after a set read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lookup_q <= 1'b0;
      reread_q <= 1'b0;
    end else begin
      lookup_q <= rd_en;
      reread_q <= fill_done;
    end
  end

  // new fetch, or re-read of the set once the line is written
  assign rd_en    = ins_req | reread_q;
  assign rd_index = ins_req ? cpu_addr[index_lsb +: index_w] : addr_q[index_lsb +: index_w];

  assign hit0 = valid0 && (tag0 == addr_q[tag_lsb +: tag_w]);
  assign hit1 = valid1 && (tag1 == addr_q[tag_lsb +: tag_w]);
  assign hit  = hit0 | hit1;

  assign hit_valid = lookup_q & hit;
  assign hit_way   = hit1;
  assign hit_index = addr_q[index_lsb +: index_w];

  assign miss      = lookup_q & ~hit;
  assign miss_addr = addr_q;

  // word select within the hit line
  assign hit_line    = hit1 ? line1 : line0;
  assign word_sel    = addr_q[word_lsb +: word_sel_w];
  assign instruction = hit_line[word_sel * addr_w +: addr_w];

  // covers miss detect, burst, line write and re-read
  assign stall = miss | dram_req | fill_done | reread_q;

endmodule

`default_nettype wire

// ==== inst_mem.sv ====
`default_nettype none

module inst_mem
  import icache_pkg::*;
#(
  parameter int mem_latency = 6
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              dram_req,
  input  logic [addr_w-1:0] dram_req_addr,
  output logic [addr_w-1:0] dram_data,
  output logic              dram_val
);

  localparam int cnt_w = $clog2(mem_latency + line_words) + 1;
  localparam logic [cnt_w-1:0] first_cnt = cnt_w'(mem_latency);
  localparam logic [cnt_w-1:0] last_cnt = cnt_w'(mem_latency + line_words - 1);

  logic              req_q;
  logic              active;
  logic [cnt_w-1:0]  cnt;
  logic [cnt_w-1:0]  beat;
  logic [addr_w-1:0] base_addr;

  // ROM contents: low address half, then its inverse
  function automatic logic [addr_w-1:0] pattern_word(input logic [addr_w-1:0] a);
    return {a[31:0], ~a[31:0]};
  endfunction

  // cnt counts cycles since the request edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_q  <= 1'b0;
      active <= 1'b0;
      cnt    <= '0;
    end else begin
      req_q <= dram_req;
      if (dram_req && !req_q) begin
        active <= 1'b1;
        cnt    <= cnt_w'(1);
      end else if (active) begin
        cnt <= cnt + 1'b1;
        if (cnt == last_cnt) begin
          active <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dram_req && !req_q) begin
      base_addr <= dram_req_addr;
    end
  end

  assign beat      = cnt - first_cnt;
  assign dram_val  = active && (cnt >= first_cnt);
  assign dram_data = pattern_word(base_addr + (addr_w'(beat) << word_lsb));

endmodule

`default_nettype wire

// ==== icache_top.sv ====
`default_nettype none

module icache_top
  import icache_pkg::*;
#(
  parameter int mem_latency = 6
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              ins_req,
  input  logic [addr_w-1:0] cpu_addr,
  output logic [addr_w-1:0] instruction,
  output logic              stall,
  output logic              dram_req
);

  logic               rd_en;
  logic [index_w-1:0] rd_index;
  logic               valid0;
  logic               valid1;
  logic [tag_w-1:0]   tag0;
  logic [tag_w-1:0]   tag1;
  logic [line_w-1:0]  line0;
  logic [line_w-1:0]  line1;
  logic               hit_valid;
  logic               hit_way;
  logic [index_w-1:0] hit_index;
  logic               miss;
  logic [addr_w-1:0]  miss_addr;
  logic               victim_way;
  logic [addr_w-1:0]  dram_req_addr;
  logic [addr_w-1:0]  dram_data;
  logic               dram_val;
  logic               fill_done;
  logic [index_w-1:0] fill_index;
  logic [tag_w-1:0]   fill_tag;
  logic [line_w-1:0]  fill_line;

  icache_ctrl icache_ctrl_i (
    .clk, .rst_n, .ins_req, .cpu_addr,
    .valid0, .valid1, .tag0, .tag1, .line0, .line1,
    .fill_done, .dram_req,
    .rd_en, .rd_index, .hit_valid, .hit_way, .hit_index,
    .miss, .miss_addr, .instruction, .stall
  );

  icache_ways icache_ways_i (
    .clk, .rst_n, .rd_en, .rd_index,
    .wr_en(fill_done), .wr_index(fill_index), .wr_way(victim_way),
    .wr_tag(fill_tag), .wr_line(fill_line),
    .valid0, .valid1, .tag0, .tag1, .line0, .line1
  );

  icache_lru icache_lru_i (
    .clk, .rst_n, .hit_valid, .hit_way, .hit_index,
    .fill_index, .valid0, .valid1, .victim_way
  );

  icache_refill icache_refill_i (
    .clk, .rst_n, .miss, .miss_addr, .dram_data, .dram_val,
    .dram_req, .dram_req_addr, .fill_done, .fill_index, .fill_tag, .fill_line
  );

  inst_mem #(
    .mem_latency(mem_latency)
  ) inst_mem_i (
    .clk, .rst_n, .dram_req, .dram_req_addr, .dram_data, .dram_val
  );

endmodule

`default_nettype wire

// ==== icache_chk.sv ====
`default_nettype none

module icache_chk (
  input logic clk,
  input logic rst_n,
  input logic ins_req,
  input logic stall,
  input logic dram_req,
  input logic dram_val,
  input logic fill_done
);

  int unsigned fail_count;

  initial fail_count = 0;

  // one cycle after any reset edge
  reset_idle: assert property (@(posedge clk) !rst_n |=> !stall && !dram_req && !fill_done)
    else begin
      $error("FAILED at %0t: stall,dram_req,fill_done = %b, expected 000", $time,
             {$sampled(stall), $sampled(dram_req), $sampled(fill_done)});
      fail_count++;
    end

  // fill_done only after four back to back beats
  four_beats: assert property (@(posedge clk) disable iff (!rst_n)
    fill_done |-> $past(dram_val, 1) && $past(dram_val, 2) &&
                  $past(dram_val, 3) && $past(dram_val, 4))
    else begin
      $error("FAILED at %0t: dram_val beats before fill_done = %b, expected 1111", $time,
             {$past(dram_val, 4), $past(dram_val, 3), $past(dram_val, 2), $past(dram_val, 1)});
      fail_count++;
    end

  // memory beats only inside an open request
  beat_in_req: assert property (@(posedge clk) disable iff (!rst_n) dram_val |-> dram_req)
    else begin
      $error("FAILED at %0t: dram_req with dram_val = %0b, expected 1", $time,
             $sampled(dram_req));
      fail_count++;
    end

  // re-read of the new line has to hit
  stall_after_fill: assert property (@(posedge clk) disable iff (!rst_n)
    $past(fill_done, 2) |-> !stall)
    else begin
      $error("FAILED at %0t: stall two cycles after fill_done = %0b, expected 0", $time,
             $sampled(stall));
      fail_count++;
    end

  // no fetch while stalled
  req_when_free: assert property (@(posedge clk) disable iff (!rst_n) ins_req |-> !stall)
    else begin
      $error("FAILED at %0t: stall with ins_req = %0b, expected 0", $time, $sampled(stall));
      fail_count++;
    end

endmodule

bind icache_top icache_chk icache_chk_i (
  .clk, .rst_n, .ins_req, .stall, .dram_req, .dram_val, .fill_done
);

`default_nettype wire

// ==== icache_tb.sv ====
`default_nettype none

module icache_tb
  import icache_pkg::*;
();

  localparam int mem_latency = 6;
  localparam int directed_fetches = 14;
  localparam int random_fetches = 200;
  localparam int num_fetches = directed_fetches + random_fetches;
  localparam int watchdog_limit = num_fetches * (mem_latency + 12) * 8 + 400;

  localparam logic [tag_w-1:0] tag_a = 53'h12;
  localparam logic [tag_w-1:0] tag_b = 53'h345;
  localparam logic [tag_w-1:0] tag_c = 53'h1_0000_0678;

  logic              clk;
  logic              rst_n;
  logic              ins_req;
  logic [addr_w-1:0] cpu_addr;
  logic [addr_w-1:0] instruction;
  logic              stall;
  logic              dram_req;

  // reference tag store of both ways with ages
  logic              m_valid [2][64];
  logic [tag_w-1:0]  m_tag   [2][64];
  int                m_age   [2][64];
  logic [31:0]       lfsr;

  icache_top #(
    .mem_latency(mem_latency)
  ) icache_top_i (
    .clk, .rst_n, .ins_req, .cpu_addr, .instruction, .stall, .dram_req
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[6:0], lfsr[0]};
    end
  endtask

  // ROM word of the aligned address
  function automatic logic [addr_w-1:0] pattern_of(input logic [addr_w-1:0] a);
    logic [31:0] al;
    al = {a[31:3], 3'b000};
    return {al, ~al};
  endfunction

  function automatic logic [addr_w-1:0] make_addr(input logic [tag_w-1:0] t,
      input logic [index_w-1:0] s, input logic [1:0] w, input logic [2:0] b);
    return {t, s, w, b};
  endfunction

  function automatic logic [tag_w-1:0] tag_choice(input logic [1:0] r);
    case (r)
      2'd0:    return tag_a;
      2'd1:    return tag_b;
      default: return tag_c;
    endcase
  endfunction

  function automatic logic model_hit(input logic [addr_w-1:0] a);
    logic [index_w-1:0] s;
    s = a[10:5];
    return (m_valid[0][s] && m_tag[0][s] == a[63:11]) ||
           (m_valid[1][s] && m_tag[1][s] == a[63:11]);
  endfunction

  task automatic update_model(input logic [addr_w-1:0] a);
    logic [index_w-1:0] s;
    logic               w;
    s = a[10:5];
    if (m_valid[0][s] && m_tag[0][s] == a[63:11]) begin
      w = 1'b0;
    end else if (m_valid[1][s] && m_tag[1][s] == a[63:11]) begin
      w = 1'b1;
    end else begin
      if (!m_valid[0][s]) begin
        w = 1'b0;
      end else if (!m_valid[1][s]) begin
        w = 1'b1;
      end else begin
        w = (m_age[0][s] > m_age[1][s]) ? 1'b0 : 1'b1;
      end
      m_valid[w][s] = 1'b1;
      m_tag[w][s] = a[63:11];
    end
    // the re-read after a refill ages the set like a hit
    m_age[w][s] = 0;
    if (m_age[~w][s] < 15) begin
      m_age[~w][s]++;
    end
  endtask

  task automatic abort_run();
    $display("RESULT: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic value_mismatch(input string name, input logic [addr_w-1:0] got,
      input logic [addr_w-1:0] want);
    $display("FAILED at time %0t: %s = %h, expected %h", $time, name, got, want);
    abort_run();
  endtask

  task automatic report_error(input string what);
    $display("error at time %0t: %s", $time, what);
    abort_run();
  endtask

  task automatic fetch(input logic [addr_w-1:0] a, input logic want_hit);
    int   waited;
    int   beats;
    logic req_seen;
    waited = 0;
    beats = 0;
    req_seen = 1'b0;
    @(posedge clk);
    #1;
    ins_req = 1'b1;
    cpu_addr = a;
    @(posedge clk);
    #1;
    ins_req = 1'b0;
    while (stall) begin
      if (dram_req) begin
        req_seen = 1'b1;
        if (icache_top_i.dram_val) begin
          beats++;
        end
      end else if (req_seen) begin
        assert (beats == line_words)
          else report_error($sformatf("dram_req fell after %0d beats", beats));
      end
      @(posedge clk);
      #1;
      waited++;
    end
    if (want_hit) begin
      assert (waited == 0 && !req_seen && !dram_req)
        else report_error($sformatf("fetch of %h missed, %0d stall cycles", a, waited));
    end else begin
      assert (req_seen && beats == line_words && !dram_req)
        else report_error($sformatf("fetch of %h did no full refill", a));
    end
    assert (instruction === pattern_of(a))
      else value_mismatch("instruction", instruction, pattern_of(a));
    update_model(a);
  endtask

  initial begin
    #(watchdog_limit);
    report_error("timeout, the fetch sequence did not finish");
  end

  always @(negedge clk) begin
    if (icache_top_i.icache_chk_i.fail_count != 0) begin
      report_error("a concurrent assertion in icache_chk failed");
    end
  end

  initial begin
    logic [7:0]        r_set;
    logic [7:0]        r_tag;
    logic [7:0]        r_word;
    logic [7:0]        r_byte;
    logic [addr_w-1:0] addr;
    rst_n = 1'b0;
    ins_req = 1'b0;
    cpu_addr = '0;
    lfsr = 32'h2879_0087;
    for (int w = 0; w < 2; w++) begin
      for (int s = 0; s < 64; s++) begin
        m_valid[w][s] = 1'b0;
        m_tag[w][s] = '0;
        m_age[w][s] = 0;
      end
    end
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (3) begin
      @(posedge clk);
      #1;
      assert (!stall && !dram_req)
        else report_error("stall or dram_req high after reset");
    end

    // set 5 holds A, B, C in turn
    fetch(make_addr(tag_a, 6'd5, 2'd0, 3'd0), 1'b0);
    fetch(make_addr(tag_a, 6'd5, 2'd1, 3'd3), 1'b1);
    fetch(make_addr(tag_a, 6'd5, 2'd3, 3'd7), 1'b1);
    fetch(make_addr(tag_b, 6'd5, 2'd2, 3'd0), 1'b0);
    fetch(make_addr(tag_b, 6'd5, 2'd0, 3'd4), 1'b1);
    fetch(make_addr(tag_a, 6'd5, 2'd1, 3'd0), 1'b1);
    fetch(make_addr(tag_c, 6'd5, 2'd3, 3'd0), 1'b0);
    fetch(make_addr(tag_a, 6'd5, 2'd0, 3'd0), 1'b1);
    fetch(make_addr(tag_b, 6'd5, 2'd0, 3'd0), 1'b0);
    fetch(make_addr(tag_c, 6'd5, 2'd1, 3'd2), 1'b0);
    fetch(make_addr(tag_b, 6'd5, 2'd3, 3'd0), 1'b1);
    fetch(make_addr(tag_a, 6'd5, 2'd2, 3'd0), 1'b0);
    fetch(make_addr(tag_a, 6'd6, 2'd0, 3'd0), 1'b0);
    fetch(make_addr(tag_a, 6'd5, 2'd0, 3'd1), 1'b1);

    // 8 sets and 3 tags force reuse and eviction
    for (int n = 0; n < random_fetches; n++) begin
      take_bits(3, r_set);
      take_bits(2, r_tag);
      take_bits(2, r_word);
      take_bits(3, r_byte);
      addr = make_addr(tag_choice(r_tag[1:0]), {r_set[2:0], 3'b101}, r_word[1:0], r_byte[2:0]);
      fetch(addr, model_hit(addr));
    end

    @(negedge clk);
    if (icache_top_i.icache_chk_i.fail_count == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
icache_pkg.sv
icache_ways.sv
icache_lru.sv
icache_refill.sv
icache_ctrl.sv
inst_mem.sv
icache_top.sv
icache_chk.sv
icache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the instruction cache testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --top-module icache_tb -Mdir obj_dir -f vlog.f \
  && { ./obj_dir/Vicache_tb +verilator+error+limit+100 2>&1 | tee sim.log; } \
  && grep -qx "RESULT: PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
